// File: hdl/flit_pkg.sv
`default_nettype none

package flit_pkg;

  // Coordinates and group ids share one width
  localparam int coord_w = 2;
  localparam int data_w  = 16;

  typedef logic [coord_w-1:0] coord_t;

  // Hierarchical destination, the group is compared first
  typedef struct packed {
    coord_t group;
    coord_t x;
    coord_t y;
  } dest_t;

  // Valid sits in the top bit, the payload in the low bits
  typedef struct packed {
    logic              valid;
    dest_t             dest;
    logic [data_w-1:0] data;
  } flit_t;

endpackage

`default_nettype wire

// File: hdl/router_pkg.sv
`default_nettype none

package router_pkg;

  import flit_pkg::*;

  localparam int num_ports = 5;

  // Port order also fixes the bit position in every port vector
  typedef enum logic [2:0] {
    port_west  = 3'd0, // Also the way out to the group gateway
    port_east  = 3'd1,
    port_south = 3'd2,
    port_north = 3'd3,
    port_local = 3'd4
  } port_e;

  typedef logic [num_ports-1:0] port_vec_t;

  // Indexed [input][output]
  typedef port_vec_t [num_ports-1:0] req_matrix_t;

  // Indexed [output][input]
  typedef port_vec_t [num_ports-1:0] grant_matrix_t;

  typedef flit_t [num_ports-1:0] flit_array_t;

endpackage

`default_nettype wire

// File: hdl/route_decoder.sv
`default_nettype none

module route_decoder #(
  parameter flit_pkg::coord_t self_x   = '0,
  parameter flit_pkg::coord_t self_y   = '0,
  parameter flit_pkg::coord_t group_id = '0
) (
  input  flit_pkg::flit_t     flit,
  output router_pkg::port_vec_t req
);

  import flit_pkg::*;
  import router_pkg::*;

  dest_t dest;
  logic  in_group;

  assign dest     = flit.dest;
  assign in_group = (dest.group == group_id);

  // X is resolved before Y, so a flit never turns back onto the x axis
  always_comb begin
    // A foreign group goes to the gateway on the west port
    req[port_west]  = flit.valid && (!in_group || (dest.x < self_x));
    req[port_east]  = flit.valid && in_group && (dest.x > self_x);
    req[port_south] = flit.valid && in_group && (dest.x == self_x) && (dest.y < self_y);
    req[port_north] = flit.valid && in_group && (dest.x == self_x) && (dest.y > self_y);
    req[port_local] = flit.valid && in_group && (dest.x == self_x) && (dest.y == self_y);
  end

  // Each direction is decoded on its own, so the terms must split the address space exactly
  always_comb begin
    a_req_shape: assert final (flit.valid ? $onehot(req) : (req == '0))
      else $error("route_decoder request vector malformed: %b", req);
  end

endmodule

`default_nettype wire

// File: hdl/switch_allocator.sv
`default_nettype none

module switch_allocator (
  input  logic                      clk,
  input  logic                      rst_n,
  input  router_pkg::req_matrix_t   req,
  output router_pkg::grant_matrix_t grant
);

  import router_pkg::*;

  port_vec_t [num_ports-1:0] req_by_out; // Row o lists the inputs asking for output o
  port_e                     ptr_q [num_ports];
  port_e                     winner [num_ports];

  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        req_by_out[o][i] = req[i][o];
      end
    end
  end

  // Search upward from the pointer and wrap, first requester wins
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    grant = '0;
    for (int o = 0; o < num_ports; o++) begin
      found     = 1'b0;
      winner[o] = ptr_q[o];
      for (int k = 0; k < num_ports; k++) begin
        idx = (int'(ptr_q[o]) + k) % num_ports;
        if (!found && req_by_out[o][idx]) begin
          found          = 1'b1;
          winner[o]      = port_e'(idx);
          grant[o][idx]  = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int o = 0; o < num_ports; o++) begin
        ptr_q[o] <= port_west;
      end
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        if (|grant[o]) begin
          // The winner drops to lowest priority on this output
          ptr_q[o] <= (winner[o] == port_local) ? port_west : port_e'(winner[o] + 3'd1);
        end
      end
    end
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_check_out
    a_grant_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(grant[o])
    ) else $error("Output %0d granted more than one input", o);

    // Checked against the raw request matrix so the transpose is covered too
    for (genvar i = 0; i < num_ports; i++) begin : g_check_in
      a_grant_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant[o][i] |-> req[i][o]
      ) else $error("Output %0d granted input %0d without a request", o, i);
    end
  end

endmodule

`default_nettype wire

// File: hdl/crossbar_stage.sv
`default_nettype none

module crossbar_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  router_pkg::grant_matrix_t grant,
  input  router_pkg::flit_array_t   in_flits,
  output router_pkg::flit_array_t   out_flits
);

  import flit_pkg::*;
  import router_pkg::*;

  flit_t [num_ports-1:0] sel_flit;
  port_vec_t             valid_q;
  dest_t                 dest_q [num_ports];
  logic [data_w-1:0]     data_q [num_ports];

  // Grant rows are one-hot, so the last match is the only match
  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      sel_flit[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        if (grant[o][i]) begin
          sel_flit[o] = in_flits[i];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      for (int o = 0; o < num_ports; o++) begin
        valid_q[o] <= |grant[o]; // An output with no grant goes idle next cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < num_ports; o++) begin
      dest_q[o] <= sel_flit[o].dest;
      data_q[o] <= sel_flit[o].data;
    end
  end

  for (genvar o = 0; o < num_ports; o++) begin : g_out
    assign out_flits[o] = '{valid: valid_q[o], dest: dest_q[o], data: data_q[o]};

    a_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$isunknown(out_flits[o].valid)
    ) else $error("Output %0d valid is unknown", o);
  end

endmodule

`default_nettype wire

// File: hdl/mesh_router.sv
`default_nettype none

module mesh_router #(
  parameter flit_pkg::coord_t self_x   = '0,
  parameter flit_pkg::coord_t self_y   = '0,
  parameter flit_pkg::coord_t group_id = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  router_pkg::flit_array_t in_flits,
  output router_pkg::flit_array_t out_flits
);

  import router_pkg::*;

  req_matrix_t   req;
  grant_matrix_t grant;

  // One decoder per input port, each fills its own request row
  for (genvar p = 0; p < num_ports; p++) begin : g_decode
    route_decoder #(
      .self_x   (self_x),
      .self_y   (self_y),
      .group_id (group_id)
    ) u_route_decoder (
      .flit (in_flits[p]),
      .req  (req[p])
    );
  end

  switch_allocator u_switch_allocator (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .grant (grant)
  );

  // The only register stage between input and output
  crossbar_stage u_crossbar_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .in_flits  (in_flits),
    .out_flits (out_flits)
  );

endmodule

`default_nettype wire

// File: testbench/tb_mesh_router.sv
`default_nettype none

module tb_mesh_router;

  timeunit 1ns;
  timeprecision 1ps;

  import flit_pkg::*;
  import router_pkg::*;

  localparam coord_t node_x     = 2'd2;
  localparam coord_t node_y     = 2'd1;
  localparam coord_t node_group = 2'd1;

  localparam int num_lines  = 30;
  localparam int cols       = 2 * num_ports; // Five inputs, then five expected outputs
  localparam int max_cycles = num_lines + 20;

  logic        clk;
  logic        rst_n;
  flit_array_t in_flits;
  flit_array_t out_flits;

  logic [$bits(flit_t)-1:0] vec_mem [0:num_lines*cols-1];
  int                       cycle_count = 0;

  mesh_router #(
    .self_x   (node_x),
    .self_y   (node_y),
    .group_id (node_group)
  ) u_mesh_router (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flits  (in_flits),
    .out_flits (out_flits)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Guards against a run that never reaches the end of the vector file
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > max_cycles) begin
      $display("Timeout: the run went past %0d clock cycles", max_cycles);
      abort_run();
    end
  end

  function automatic string port_label(input int p, input string field);
    port_e dir;
    dir = port_e'(p);
    return $sformatf("out_flits[%s]%s", dir.name(), field);
  endfunction

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idle();
    for (int p = 0; p < num_ports; p++) begin
      check_valid(port_label(p, ".valid"), out_flits[p].valid, 1'b0);
    end
  endtask

  // Expected columns of a line describe the outputs one clock after its inputs
  task automatic check_line(input int n);
    flit_t exp;
    for (int p = 0; p < num_ports; p++) begin
      exp = vec_mem[n*cols + num_ports + p];
      check_valid(port_label(p, ".valid"), out_flits[p].valid, exp.valid);
      if (exp.valid) begin
        check_flit(port_label(p, ""), out_flits[p], exp); // Payload and destination too
      end
    end
  endtask

  initial begin
    int n;
    in_flits = '0;
    rst_n    = 1'b0;
    $readmemh("testbench/router_input.txt", vec_mem);
    if ($isunknown(vec_mem[num_lines*cols-1])) begin
      $display("The vector file is missing or holds fewer than %0d lines", num_lines);
      abort_run();
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_idle(); // Still in reset here
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle();

    // One extra pass drains the last line through the output register
    for (n = 0; n <= num_lines; n++) begin
      @(posedge clk);
      for (int p = 0; p < num_ports; p++) begin
        if (n < num_lines) begin
          in_flits[p] <= flit_t'(vec_mem[n*cols + p]);
        end else begin
          in_flits[p] <= '0;
        end
      end
      @(negedge clk);
      if (n > 0) begin
        check_line(n - 1);
      end
    end

    @(negedge clk);
    check_idle();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/router_input.txt
// Cols 1-5: input flits on west east south north local (valid, group, x, y, data as hex)
// Cols 6-10: expected output flits one clock later on west east south north local
// Idle after reset
000000 000000 000000 000000 000000  000000 000000 000000 000000 000000
000000 000000 000000 000000 000000  000000 000000 000000 000000 000000
000000 000000 000000 000000 000000  000000 000000 000000 000000 000000
// Single flits to each direction, node at x 2 y 1 in group 1
5D1111 000000 000000 000000 000000  000000 5D1111 000000 000000 000000
000000 551222 000000 000000 000000  551222 000000 000000 000000 000000
000000 000000 000000 583333 000000  000000 000000 583333 000000 000000
000000 000000 5A4444 000000 000000  000000 000000 000000 5A4444 000000
595555 000000 000000 000000 000000  000000 000000 000000 000000 595555
000000 000000 000000 000000 5B6666  000000 000000 000000 5B6666 000000
000000 000000 507777 000000 000000  507777 000000 000000 000000 000000
// Foreign groups go west whatever their coordinates
498001 000000 000000 000000 000000  498001 000000 000000 000000 000000
000000 000000 000000 000000 6D8002  6D8002 000000 000000 000000 000000
000000 7A8003 000000 000000 000000  7A8003 000000 000000 000000 000000
000000 000000 5D8004 4D8005 000000  4D8005 5D8004 000000 000000 000000
// All five inputs fight for local, the pointer starts at 1
59A000 59A001 59A002 59A003 59A004  000000 000000 000000 000000 59A001
59A010 59A011 59A012 59A013 59A014  000000 000000 000000 000000 59A012
59A020 59A021 59A022 59A023 59A024  000000 000000 000000 000000 59A023
59A030 59A031 59A032 59A033 59A034  000000 000000 000000 000000 59A034
59A040 59A041 59A042 59A043 59A044  000000 000000 000000 000000 59A040
// West and north inputs share south, the pointer starts at 4
58B000 000000 000000 58B003 000000  000000 000000 58B000 000000 000000
58B010 000000 000000 58B013 000000  000000 000000 58B013 000000 000000
58B020 000000 000000 58B023 000000  000000 000000 58B020 000000 000000
// Three inputs share west, two of them from other groups
000000 40C001 75C002 000000 55C004  55C004 000000 000000 000000 000000
000000 40C011 75C012 000000 55C014  40C011 000000 000000 000000 000000
000000 40C021 75C022 000000 55C024  75C022 000000 000000 000000 000000
// Five disjoint routes on back to back cycles
5DD000 55D001 5AD002 58D003 59D004  55D001 5DD000 58D003 5AD002 59D004
59D010 5BD011 51D012 5DD013 58D014  51D012 5DD013 58D014 5BD011 59D010
58D020 59D021 5ED022 65D023 5AD024  65D023 5ED022 58D020 5AD024 59D021
// Outputs fall idle again
000000 000000 000000 000000 000000  000000 000000 000000 000000 000000
000000 000000 000000 000000 000000  000000 000000 000000 000000 000000

// File: all.f
hdl/flit_pkg.sv
hdl/router_pkg.sv
hdl/route_decoder.sv
hdl/switch_allocator.sv
hdl/crossbar_stage.sv
hdl/mesh_router.sv
testbench/tb_mesh_router.sv
